// File: bench/icache_assert.sv
`timescale 1ns/1ps

module icache_assert (
    input logic clk,
    input logic arst_n,
    input logic fetch_en,
    input logic l2_we,
    input logic mem_we,
    input logic hit,
    input logic miss
);

    // a fetch with no refill in its cycle gives exactly one of hit and miss next cycle
    result_after_fetch: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fetch_en && !l2_we && !mem_we) |=> (hit != miss)
    ) else $error("no single hit or miss one cycle after an accepted fetch");

    // a dropped or absent fetch leaves both low
    no_result_without_fetch: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(fetch_en && !l2_we && !mem_we) |=> (!hit && !miss)
    ) else $error("hit or miss reported without an accepted fetch");

endmodule

bind icache_top icache_assert u_icache_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .fetch_en(fetch_en),
    .l2_we   (l2_we),
    .mem_we  (mem_we),
    .hit     (hit),
    .miss    (miss)
);

// File: bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int NUM_ROWS    = 18;
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = (NUM_ROWS + 20) * CLK_NS * 4;

    localparam logic [2:0] K_FETCH    = 3'd0;
    localparam logic [2:0] K_L2       = 3'd1;
    localparam logic [2:0] K_MEM      = 3'd2;
    localparam logic [2:0] K_BOTH     = 3'd3;
    localparam logic [2:0] K_FETCH_WR = 3'd4;   // L2 refill from side a, fetch from side b

    localparam logic [1:0] R_NONE = 2'd0;       // no result in the next cycle
    localparam logic [1:0] R_HIT  = 2'd1;
    localparam logic [1:0] R_MISS = 2'd2;

    localparam logic [TAG_W-1:0] TAG_A = 21'h12345;
    localparam logic [TAG_W-1:0] TAG_B = 21'h0abcd;
    localparam logic [TAG_W-1:0] TAG_C = 21'h1f00f;
    localparam logic [TAG_W-1:0] TAG_D = 21'h00777;
    localparam logic [TAG_W-1:0] TAG_E = 21'h15a5a;

    typedef struct packed {
        logic [2:0]        kind;
        logic              way_a;
        logic [ADDR_W-1:0] addr_a;
        logic [THR_W-1:0]  thr_a;
        logic              way_b;
        logic [ADDR_W-1:0] addr_b;
        logic [THR_W-1:0]  thr_b;
        logic [1:0]        res;
        logic              exp_way;
        logic              exp_victim;
    } row_t;

    logic              clk;
    logic              arst_n;
    logic              fetch_en;
    logic [ADDR_W-1:0] fetch_addr;
    logic [THR_W-1:0]  fetch_thread;
    logic              l2_we;
    logic              l2_way;
    logic [ADDR_W-1:0] l2_addr;
    logic [THR_W-1:0]  l2_thread;
    logic [LINE_W-1:0] l2_line;
    logic              mem_we;
    logic              mem_way;
    logic [ADDR_W-1:0] mem_addr;
    logic [THR_W-1:0]  mem_thread;
    logic [LINE_W-1:0] mem_line;
    logic              hit;
    logic              miss;
    logic              hit_way;
    logic [WORD_W-1:0] insn;
    logic              victim_way;

    row_t              rows [NUM_ROWS];
    logic [WORD_W-1:0] exp_insn [NUM_ROWS];   // from the shadow lines
    logic [TAG_W-1:0]  sh_tag [2][DEPTH];
    logic [THR_W-1:0]  sh_thr [2][DEPTH];
    logic [LINE_W-1:0] sh_line [2][DEPTH];
    logic              sh_lru [DEPTH];
    integer            seed;
    int                error_count;
    int                fail_rows;
    int                row_errors;

    icache_top u_icache_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .fetch_thread(fetch_thread),
        .l2_we       (l2_we),
        .l2_way      (l2_way),
        .l2_addr     (l2_addr),
        .l2_thread   (l2_thread),
        .l2_line     (l2_line),
        .mem_we      (mem_we),
        .mem_way     (mem_way),
        .mem_addr    (mem_addr),
        .mem_thread  (mem_thread),
        .mem_line    (mem_line),
        .hit         (hit),
        .miss        (miss),
        .hit_way     (hit_way),
        .insn        (insn),
        .victim_way  (victim_way)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [IDX_W-1:0] idx,
                                                   input logic wsel);
        return {tag, idx, wsel, 2'b00};
    endfunction

    function automatic row_t fetch_row(input logic [ADDR_W-1:0] addr, input logic [THR_W-1:0] thr,
                                       input logic [1:0] res, input logic way,
                                       input logic victim);
        row_t r;
        r            = '0;
        r.kind       = K_FETCH;
        r.addr_a     = addr;
        r.thr_a      = thr;
        r.res        = res;
        r.exp_way    = way;
        r.exp_victim = victim;
        return r;
    endfunction

    function automatic row_t refill_row(input logic [2:0] kind, input logic way_a,
                                        input logic [ADDR_W-1:0] addr_a,
                                        input logic [THR_W-1:0] thr_a, input logic way_b,
                                        input logic [ADDR_W-1:0] addr_b,
                                        input logic [THR_W-1:0] thr_b);
        row_t r;
        r        = '0;
        r.kind   = kind;
        r.way_a  = way_a;
        r.addr_a = addr_a;
        r.thr_a  = thr_a;
        r.way_b  = way_b;
        r.addr_b = addr_b;
        r.thr_b  = thr_b;
        r.res    = R_NONE;
        return r;
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            K_FETCH: return "fetch";
            K_L2:    return "l2 refill";
            K_MEM:   return "mem refill";
            K_BOTH:  return "both refills";
            default: return "fetch during refill";
        endcase
    endfunction

    task automatic fill_table();
        rows[0]  = fetch_row(make_addr(TAG_A, 8'd5, 1'b0), 2'd1, R_MISS, 1'b0, 1'b0);
        rows[1]  = refill_row(K_L2, 1'b0, make_addr(TAG_A, 8'd5, 1'b0), 2'd1, 1'b0, '0, '0);
        rows[2]  = fetch_row(make_addr(TAG_A, 8'd5, 1'b0), 2'd1, R_HIT, 1'b0, 1'b1);
        rows[3]  = fetch_row(make_addr(TAG_A, 8'd5, 1'b1), 2'd1, R_HIT, 1'b0, 1'b1);
        rows[4]  = refill_row(K_MEM, 1'b0, '0, '0, 1'b1, make_addr(TAG_B, 8'd5, 1'b0), 2'd2);
        rows[5]  = fetch_row(make_addr(TAG_B, 8'd5, 1'b1), 2'd2, R_HIT, 1'b1, 1'b0);
        rows[6]  = fetch_row(make_addr(TAG_A, 8'd5, 1'b0), 2'd1, R_HIT, 1'b0, 1'b0);
        rows[7]  = fetch_row(make_addr(TAG_B, 8'd5, 1'b0), 2'd1, R_MISS, 1'b0, 1'b0);
        rows[8]  = fetch_row(make_addr(TAG_A, 8'd5, 1'b1), 2'd3, R_MISS, 1'b0, 1'b0);
        rows[9]  = refill_row(K_BOTH, 1'b0, make_addr(TAG_C, 8'd9, 1'b0), 2'd1,
                              1'b1, make_addr(TAG_D, 8'd9, 1'b0), 2'd2);
        rows[10] = fetch_row(make_addr(TAG_C, 8'd9, 1'b1), 2'd1, R_HIT, 1'b0, 1'b1);
        rows[11] = fetch_row(make_addr(TAG_D, 8'd9, 1'b0), 2'd2, R_MISS, 1'b0, 1'b1);
        rows[12] = refill_row(K_FETCH_WR, 1'b1, make_addr(TAG_E, 8'd9, 1'b0), 2'd3,
                              1'b0, make_addr(TAG_C, 8'd9, 1'b0), 2'd1);
        rows[13] = fetch_row(make_addr(TAG_E, 8'd9, 1'b0), 2'd3, R_HIT, 1'b1, 1'b0);
        rows[14] = fetch_row(make_addr(TAG_C, 8'd9, 1'b0), 2'd1, R_HIT, 1'b0, 1'b0);
        rows[15] = fetch_row(make_addr(TAG_A, 8'd5, 1'b1), 2'd1, R_HIT, 1'b0, 1'b0);
        rows[16] = fetch_row(make_addr(TAG_B, 8'd5, 1'b0), 2'd2, R_HIT, 1'b1, 1'b0);
        rows[17] = fetch_row(make_addr(TAG_A, 8'd200, 1'b0), 2'd1, R_MISS, 1'b0, 1'b0);
    endtask

    task automatic drive_idle();
        fetch_en     = 1'b0;
        fetch_addr   = '0;
        fetch_thread = '0;
        l2_we        = 1'b0;
        l2_way       = 1'b0;
        l2_addr      = '0;
        l2_thread    = '0;
        l2_line      = '0;
        mem_we       = 1'b0;
        mem_way      = 1'b0;
        mem_addr     = '0;
        mem_thread   = '0;
        mem_line     = '0;
    endtask

    task automatic drive_l2(input row_t r, input logic [LINE_W-1:0] line);
        l2_we     = 1'b1;
        l2_way    = r.way_a;
        l2_addr   = r.addr_a;
        l2_thread = r.thr_a;
        l2_line   = line;
    endtask

    task automatic drive_mem(input row_t r, input logic [LINE_W-1:0] line);
        mem_we     = 1'b1;
        mem_way    = r.way_b;
        mem_addr   = r.addr_b;
        mem_thread = r.thr_b;
        mem_line   = line;
    endtask

    task automatic write_shadow(input logic way, input logic [ADDR_W-1:0] addr,
                                input logic [THR_W-1:0] thr, input logic [LINE_W-1:0] line);
        logic [IDX_W-1:0] idx;
        idx               = addr[10:3];
        sh_tag[way][idx]  = addr[31:11];
        sh_thr[way][idx]  = thr;
        sh_line[way][idx] = line;
        sh_lru[idx]       = ~way;       // the other way goes next
    endtask

    task automatic model_fetch(input int i, input logic [ADDR_W-1:0] addr,
                               input logic [THR_W-1:0] thr, output logic [1:0] res,
                               output logic way, output logic victim);
        logic [IDX_W-1:0]  idx;
        logic              hit0;
        logic              hit1;
        logic [LINE_W-1:0] line;
        idx    = addr[10:3];
        hit0   = (sh_thr[0][idx] != '0) && (sh_thr[0][idx] == thr)
                 && (sh_tag[0][idx] == addr[31:11]);
        hit1   = (sh_thr[1][idx] != '0) && (sh_thr[1][idx] == thr)
                 && (sh_tag[1][idx] == addr[31:11]);
        res    = (hit0 || hit1) ? R_HIT : R_MISS;
        way    = !hit0;
        victim = sh_lru[idx];
        line   = hit0 ? sh_line[0][idx] : sh_line[1][idx];
        exp_insn[i] = '0;
        if (hit0 || hit1) begin
            exp_insn[i] = addr[2] ? line[63:32] : line[31:0];
        end
    endtask

    task automatic apply_row(input int i);
        row_t              r;
        logic [LINE_W-1:0] line_a;
        logic [LINE_W-1:0] line_b;
        logic [1:0]        m_res;
        logic              m_way;
        logic              m_victim;
        r           = rows[i];
        line_a      = {$random(seed), $random(seed)};
        line_b      = {$random(seed), $random(seed)};
        m_res       = R_NONE;
        m_way       = 1'b0;
        m_victim    = 1'b0;
        exp_insn[i] = '0;
        drive_idle();
        case (r.kind)
            K_FETCH: begin
                fetch_en     = 1'b1;
                fetch_addr   = r.addr_a;
                fetch_thread = r.thr_a;
                model_fetch(i, r.addr_a, r.thr_a, m_res, m_way, m_victim);
            end
            K_L2: begin
                drive_l2(r, line_a);
                write_shadow(r.way_a, r.addr_a, r.thr_a, line_a);
            end
            K_MEM: begin
                drive_mem(r, line_b);
                write_shadow(r.way_b, r.addr_b, r.thr_b, line_b);
            end
            K_BOTH: begin
                drive_l2(r, line_a);
                drive_mem(r, line_b);
                write_shadow(r.way_a, r.addr_a, r.thr_a, line_a);   // memory side loses
            end
            default: begin
                drive_l2(r, line_a);
                write_shadow(r.way_a, r.addr_a, r.thr_a, line_a);
                fetch_en     = 1'b1;                                // dropped by the write
                fetch_addr   = r.addr_b;
                fetch_thread = r.thr_b;
            end
        endcase
        assert (r.res == m_res && (r.res != R_HIT || r.exp_way == m_way)
                && (r.res == R_NONE || r.exp_victim == m_victim)) else begin
            $display("row %0d: table entry disagrees with the shadow model", i);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %0b, expected %0b", $time, name, got, exp);
            error_count++;
            row_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            error_count++;
            row_errors++;
        end
    endtask

    task automatic check_row(input int i);
        row_t r;
        r          = rows[i];
        row_errors = 0;
        case (r.res)
            R_HIT: begin
                check_bit("hit", hit, 1'b1);
                check_bit("miss", miss, 1'b0);
                check_bit("hit_way", hit_way, r.exp_way);
                check_word("insn", insn, exp_insn[i]);
                check_bit("victim_way", victim_way, r.exp_victim);
            end
            R_MISS: begin
                check_bit("hit", hit, 1'b0);
                check_bit("miss", miss, 1'b1);
                check_word("insn", insn, '0);
                check_bit("victim_way", victim_way, r.exp_victim);
            end
            default: begin
                check_bit("hit", hit, 1'b0);
                check_bit("miss", miss, 1'b0);
            end
        endcase
        if (row_errors != 0) begin
            fail_rows++;
        end
        $display("row %0d %s: %s", i, kind_name(r.kind), (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        seed        = 32'h0a76a7fe;
        error_count = 0;
        fail_rows   = 0;
        row_errors  = 0;
        drive_idle();
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < DEPTH; s++) begin
                sh_tag[w][s]  = '0;
                sh_thr[w][s]  = '0;         // SRAM models come up cleared
                sh_line[w][s] = '0;
                sh_lru[s]     = 1'b0;
            end
        end
        fill_table();

        // no result may show up during or right after reset
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #4;
            check_bit("hit", hit, 1'b0);
            check_bit("miss", miss, 1'b0);
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        #3;
        check_bit("hit", hit, 1'b0);
        check_bit("miss", miss, 1'b0);
        if (row_errors != 0) begin
            fail_rows++;
        end
        $display("reset: %s", (row_errors == 0) ? "ok" : "mismatch");

        // one row per cycle, its result is checked while the next row is driven
        for (int i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk);
            #1;
            if (i < NUM_ROWS) begin
                apply_row(i);
            end else begin
                drive_idle();
            end
            #3;
            if (i > 0) begin
                check_row(i - 1);
            end
        end

        $display("tests: %0d, failed tests: %0d, errors: %0d", NUM_ROWS + 1, fail_rows,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
BIN=obj_dir/icache_sim

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f sim.f \
    -o icache_sim > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $build_status"
    exit 1
fi

"$BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

# the log decides the outcome
if grep -qx "Simulation PASSED" "$SIM_LOG"; then
    echo "run passed"
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

// File: sim.f
src/icache_pkg.sv
src/icache_sram.sv
src/itag_ram.sv
src/idata_ram.sv
src/icache_lookup.sv
src/icache_top.sv
bench/icache_assert.sv
bench/icache_tb.sv

// File: src/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rd_issue,
    input  icache_pkg::ic_addr_u          fetch_addr,
    input  logic [icache_pkg::THR_W-1:0]  fetch_thread,
    input  logic [icache_pkg::TAG_W-1:0]  tag0_rd,
    input  logic [icache_pkg::TAG_W-1:0]  tag1_rd,
    input  logic [icache_pkg::THR_W-1:0]  thread0,
    input  logic [icache_pkg::THR_W-1:0]  thread1,
    input  logic                          lru,
    input  logic [icache_pkg::LINE_W-1:0] line0_rd,
    input  logic [icache_pkg::LINE_W-1:0] line1_rd,
    output logic                          hit,
    output logic                          miss,
    output logic                          hit_way,
    output logic [icache_pkg::WORD_W-1:0] insn,
    output logic                          victim_way
);
    import icache_pkg::*;

    logic             req_vld;          // a result is due this cycle
    logic [TAG_W-1:0] req_tag;
    logic             req_wsel;
    logic [THR_W-1:0] req_thread;
    logic             way0_hit;
    logic             way1_hit;
    logic [LINE_W-1:0] sel_line;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_vld <= 1'b0;
        end else begin
            req_vld <= rd_issue;
        end
    end

    // request fields line up with the array read data one cycle later
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            req_tag    <= fetch_addr.fld.tag;
            req_wsel   <= fetch_addr.fld.wsel;
            req_thread <= fetch_thread;
        end
    end

    assign way0_hit = (thread0 != THR_EMPTY) && (thread0 == req_thread) && (tag0_rd == req_tag);
    assign way1_hit = (thread1 != THR_EMPTY) && (thread1 == req_thread) && (tag1_rd == req_tag);

    assign hit     = req_vld & (way0_hit | way1_hit);
    assign miss    = req_vld & ~(way0_hit | way1_hit);
    assign hit_way = ~way0_hit & way1_hit;     // way 0 wins a double hit

    assign sel_line = way0_hit ? line0_rd : line1_rd;

    always_comb begin
        insn = '0;
        if (hit) begin
            insn = req_wsel ? sel_line[LINE_W-1:WORD_W] : sel_line[WORD_W-1:0];
        end
    end

    assign victim_way = lru;            // way to refill on a miss

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int ADDR_W = 32;         // fetch and refill address
    localparam int IDX_W  = 8;          // set index
    localparam int TAG_W  = 21;         // address tag
    localparam int THR_W  = 2;          // thread id, 0 marks an empty entry
    localparam int WORD_W = 32;         // one instruction
    localparam int LINE_W = 64;         // two instructions per line
    localparam int DEPTH  = 256;        // sets per way
    localparam int BOFF_W = 2;          // byte offset inside a word

    // empty entry code of the thread arrays
    localparam logic [THR_W-1:0] THR_EMPTY = '0;

    // one address seen either as a flat word or split into its fields
    typedef union packed {
        logic [ADDR_W-1:0] word;        // raw address
        struct packed {
            logic [TAG_W-1:0]  tag;     // bits 31..11
            logic [IDX_W-1:0]  index;   // bits 10..3
            logic              wsel;    // bit 2, upper or lower word
            logic [BOFF_W-1:0] boff;    // bits 1..0
        } fld;
    } ic_addr_u;

endpackage

// File: src/icache_sram.sv
`timescale 1ns/1ps

module icache_sram #(
    parameter int WIDTH = 1
) (
    input  logic                        clk,
    input  logic [icache_pkg::IDX_W-1:0] address,
    input  logic                        wren,
    input  logic                        rden,
    input  logic [WIDTH-1:0]            data,
    output logic [WIDTH-1:0]            q
);
    import icache_pkg::*;

    logic [WIDTH-1:0] mem [DEPTH];

    // arrays come up empty, so thread 0 reads as invalid
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
        if (rden) begin
            q <= mem[address];          // held while rden is low
        end
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          fetch_en,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    input  logic [icache_pkg::THR_W-1:0]  fetch_thread,
    input  logic                          l2_we,
    input  logic                          l2_way,
    input  logic [icache_pkg::ADDR_W-1:0] l2_addr,
    input  logic [icache_pkg::THR_W-1:0]  l2_thread,
    input  logic [icache_pkg::LINE_W-1:0] l2_line,
    input  logic                          mem_we,
    input  logic                          mem_way,
    input  logic [icache_pkg::ADDR_W-1:0] mem_addr,
    input  logic [icache_pkg::THR_W-1:0]  mem_thread,
    input  logic [icache_pkg::LINE_W-1:0] mem_line,
    output logic                          hit,
    output logic                          miss,
    output logic                          hit_way,
    output logic [icache_pkg::WORD_W-1:0] insn,
    output logic                          victim_way
);
    import icache_pkg::*;

    logic [IDX_W-1:0]  index;
    logic [LINE_W-1:0] line_wd;
    logic              line_we0;
    logic              line_we1;
    logic              rd_issue;
    logic [TAG_W-1:0]  tag0_rd;
    logic [TAG_W-1:0]  tag1_rd;
    logic [THR_W-1:0]  thread0;
    logic [THR_W-1:0]  thread1;
    logic              lru;
    logic [LINE_W-1:0] line0_rd;
    logic [LINE_W-1:0] line1_rd;

    itag_ram u_itag_ram (
        .clk       (clk),
        .fetch_en  (fetch_en),
        .fetch_addr(fetch_addr),
        .l2_we     (l2_we),
        .l2_way    (l2_way),
        .l2_addr   (l2_addr),
        .l2_thread (l2_thread),
        .l2_line   (l2_line),
        .mem_we    (mem_we),
        .mem_way   (mem_way),
        .mem_addr  (mem_addr),
        .mem_thread(mem_thread),
        .mem_line  (mem_line),
        .index     (index),
        .line_wd   (line_wd),
        .line_we0  (line_we0),
        .line_we1  (line_we1),
        .rd_issue  (rd_issue),
        .tag0_rd   (tag0_rd),
        .tag1_rd   (tag1_rd),
        .thread0   (thread0),
        .thread1   (thread1),
        .lru       (lru)
    );

    idata_ram u_idata_ram (
        .clk     (clk),
        .index   (index),
        .line_wd (line_wd),
        .line_we0(line_we0),
        .line_we1(line_we1),
        .rd_issue(rd_issue),
        .line0_rd(line0_rd),
        .line1_rd(line1_rd)
    );

    // fetch address and thread go straight to the compare stage
    icache_lookup u_icache_lookup (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_issue    (rd_issue),
        .fetch_addr  (fetch_addr),
        .fetch_thread(fetch_thread),
        .tag0_rd     (tag0_rd),
        .tag1_rd     (tag1_rd),
        .thread0     (thread0),
        .thread1     (thread1),
        .lru         (lru),
        .line0_rd    (line0_rd),
        .line1_rd    (line1_rd),
        .hit         (hit),
        .miss        (miss),
        .hit_way     (hit_way),
        .insn        (insn),
        .victim_way  (victim_way)
    );

endmodule

// File: src/idata_ram.sv
`timescale 1ns/1ps

module idata_ram (
    input  logic                          clk,
    input  logic [icache_pkg::IDX_W-1:0]  index,
    input  logic [icache_pkg::LINE_W-1:0] line_wd,
    input  logic                          line_we0,
    input  logic                          line_we1,
    input  logic                          rd_issue,
    output logic [icache_pkg::LINE_W-1:0] line0_rd,
    output logic [icache_pkg::LINE_W-1:0] line1_rd
);
    import icache_pkg::*;

    // line store for way 0, sits beside tag_way0
    icache_sram #(.WIDTH(LINE_W)) data_way0 (
        .clk    (clk),
        .address(index),
        .wren   (line_we0),
        .rden   (rd_issue),       // both ways read on every fetch
        .data   (line_wd),
        .q      (line0_rd)
    );

    // line store for way 1
    icache_sram #(.WIDTH(LINE_W)) data_way1 (
        .clk    (clk),
        .address(index),
        .wren   (line_we1),
        .rden   (rd_issue),
        .data   (line_wd),
        .q      (line1_rd)
    );

endmodule

// File: src/itag_ram.sv
`timescale 1ns/1ps

module itag_ram (
    input  logic                          clk,
    input  logic                          fetch_en,
    input  icache_pkg::ic_addr_u          fetch_addr,
    input  logic                          l2_we,
    input  logic                          l2_way,
    input  icache_pkg::ic_addr_u          l2_addr,
    input  logic [icache_pkg::THR_W-1:0]  l2_thread,
    input  logic [icache_pkg::LINE_W-1:0] l2_line,
    input  logic                          mem_we,
    input  logic                          mem_way,
    input  icache_pkg::ic_addr_u          mem_addr,
    input  logic [icache_pkg::THR_W-1:0]  mem_thread,
    input  logic [icache_pkg::LINE_W-1:0] mem_line,
    output logic [icache_pkg::IDX_W-1:0]  index,
    output logic [icache_pkg::LINE_W-1:0] line_wd,
    output logic                          line_we0,
    output logic                          line_we1,
    output logic                          rd_issue,
    output logic [icache_pkg::TAG_W-1:0]  tag0_rd,
    output logic [icache_pkg::TAG_W-1:0]  tag1_rd,
    output logic [icache_pkg::THR_W-1:0]  thread0,
    output logic [icache_pkg::THR_W-1:0]  thread1,
    output logic                          lru
);
    import icache_pkg::*;

    logic [TAG_W-1:0] tag_wd;           // tag of the winning refill
    logic [THR_W-1:0] thread_wd;        // owner of the winning refill
    logic             lru_we;
    logic             lru_wd;

    // L2 refill first, then memory refill, then fetch
    always_comb begin
        tag_wd    = l2_addr.fld.tag;
        thread_wd = l2_thread;
        line_wd   = l2_line;
        line_we0  = 1'b0;
        line_we1  = 1'b0;
        index     = fetch_addr.fld.index;
        if (l2_we) begin
            index    = l2_addr.fld.index;
            line_we0 = ~l2_way;
            line_we1 = l2_way;
        end else if (mem_we) begin
            tag_wd    = mem_addr.fld.tag;
            thread_wd = mem_thread;
            line_wd   = mem_line;
            index     = mem_addr.fld.index;
            line_we0  = ~mem_way;
            line_we1  = mem_way;
        end
    end

    assign rd_issue = fetch_en & ~l2_we & ~mem_we;  // fetch dropped in a write cycle

    // a refill of one way makes the other one the next victim
    assign lru_we = line_we0 | line_we1;
    assign lru_wd = line_we0;

    icache_sram #(.WIDTH(TAG_W)) tag_way0 (
        .clk    (clk),
        .address(index),
        .wren   (line_we0),
        .rden   (rd_issue),
        .data   (tag_wd),
        .q      (tag0_rd)
    );

    icache_sram #(.WIDTH(TAG_W)) tag_way1 (
        .clk    (clk),
        .address(index),
        .wren   (line_we1),
        .rden   (rd_issue),
        .data   (tag_wd),
        .q      (tag1_rd)
    );

    icache_sram #(.WIDTH(THR_W)) thread0_field (
        .clk    (clk),
        .address(index),
        .wren   (line_we0),
        .rden   (rd_issue),
        .data   (thread_wd),
        .q      (thread0)
    );

    icache_sram #(.WIDTH(THR_W)) thread1_field (
        .clk    (clk),
        .address(index),
        .wren   (line_we1),
        .rden   (rd_issue),
        .data   (thread_wd),
        .q      (thread1)
    );

    icache_sram #(.WIDTH(1)) lru_field (
        .clk    (clk),
        .address(index),
        .wren   (lru_we),
        .rden   (rd_issue),
        .data   (lru_wd),
        .q      (lru)
    );

endmodule
